// File: hdl/hamr_cfg_pkg.sv
// Sizes and rates of the analyzer core
// The zoom factor is 2**window, so DISPLAY_BITS << MAX_WINDOW must not
// exceed CAPTURE_LEN or a regeneration would read past the capture

package hamr_cfg_pkg;

    // ==============================
    // Sampling
    // ==============================
    localparam int unsigned NUM_CH     = 8;    // Probe channels
    localparam int unsigned SAMPLE_DIV = 4;    // Clocks per sample period

    // ==============================
    // Capture and display
    // ==============================
    localparam int unsigned CAPTURE_LEN   = 256;  // Samples per capture
    localparam int unsigned CAP_ADDR_W    = 8;    // Sample memory address bits
    localparam int unsigned DISPLAY_BITS  = 32;   // Display bits per channel
    localparam int unsigned DISPLAY_BYTES = 4;    // DISPLAY_BITS / 8
    localparam logic [1:0]  MAX_WINDOW    = 2'd3; // Largest zoom code

endpackage

// File: hdl/hamr_types_pkg.sv
// Encodings shared by the control path and the register port
// Register addresses are 3 bits; unlisted addresses read as zero

package hamr_types_pkg;

    typedef enum logic [2:0] {
        PHASE_IDLE     = 3'd0,
        PHASE_CAPTURE  = 3'd1,  // Armed or filling memory
        PHASE_CAPTURED = 3'd2,
        PHASE_REGEN    = 3'd3,  // Display buffer being rebuilt
        PHASE_READY    = 3'd4
    } phase_t;

    typedef enum logic {
        TRIG_RISING  = 1'b0,
        TRIG_FALLING = 1'b1
    } trig_mode_t;

    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,  // W: bit0 arm, bit1 regen
        REG_TRIG   = 3'd1,  // W: [2:0] channel, [3] mode
        REG_WINDOW = 3'd2,  // W: [1:0] zoom code
        REG_SEL    = 3'd3,  // W: [4:2] channel, [1:0] byte index
        REG_STATUS = 3'd4,  // R: armed, captured, busy, ready
        REG_DATA   = 3'd5   // R: selected display byte
    } reg_addr_t;

endpackage

// File: hdl/probe_sampler.sv
// Probes are asynchronous and pass a two-flop synchronizer
// One strobe per SAMPLE_DIV clocks; sample is valid while the strobe is high

module probe_sampler (
    input  logic                            clk,
    input  logic                            cmd_reset,
    input  logic [hamr_cfg_pkg::NUM_CH-1:0] probe,
    output logic                            sample_strobe,
    output logic [hamr_cfg_pkg::NUM_CH-1:0] sample
);

    logic [hamr_cfg_pkg::NUM_CH-1:0] probe_sync1;
    logic [hamr_cfg_pkg::NUM_CH-1:0] probe_sync2;
    logic [$clog2(hamr_cfg_pkg::SAMPLE_DIV)-1:0] div_cnt;

    // Synchronizer, two clocks of latency
    always_ff @(posedge clk) begin
        probe_sync1 <= probe;
        probe_sync2 <= probe_sync1;
    end

    // Sample-rate divider
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            div_cnt <= '0;
        end else if (div_cnt == hamr_cfg_pkg::SAMPLE_DIV - 1) begin
            div_cnt <= '0;                  // Wrap at end of period
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample_strobe = (div_cnt == hamr_cfg_pkg::SAMPLE_DIV - 1);
    assign sample        = probe_sync2;     // Value from count 0 has settled here

endmodule

// File: hdl/capture_engine.sv
// Waits for one edge on trig_ch, then stores CAPTURE_LEN consecutive samples
// The triggering sample lands at address 0; no pre-trigger history is kept
// Read port is synchronous, data one clock after the address

module capture_engine (
    input  logic                                clk,
    input  logic                                cmd_reset,
    input  logic                                arm_start,
    input  logic                                sample_strobe,
    input  logic [hamr_cfg_pkg::NUM_CH-1:0]     sample,
    input  logic [2:0]                          trig_ch,
    input  hamr_types_pkg::trig_mode_t          trig_mode,
    output logic                                armed,
    output logic                                capture_done,
    input  logic [hamr_cfg_pkg::CAP_ADDR_W-1:0] mem_rd_addr,
    output logic [hamr_cfg_pkg::NUM_CH-1:0]     mem_rd_data
);

    logic [hamr_cfg_pkg::NUM_CH-1:0]     sample_mem [hamr_cfg_pkg::CAPTURE_LEN];
    logic [hamr_cfg_pkg::NUM_CH-1:0]     prev_sample;
    logic [hamr_cfg_pkg::CAP_ADDR_W-1:0] wr_addr;
    logic                                triggered;     // Edge seen, filling memory
    logic                                edge_hit;
    logic                                wr_en;

    // ==============================
    // Edge detect on selected channel
    // ==============================
    assign edge_hit = (trig_mode == hamr_types_pkg::TRIG_RISING)
                    ? (sample[trig_ch] & ~prev_sample[trig_ch])
                    : (~sample[trig_ch] & prev_sample[trig_ch]);

    assign wr_en = sample_strobe && armed && (triggered || edge_hit);

    always_ff @(posedge clk) begin
        if (sample_strobe)
            prev_sample <= sample;          // Tracked even when idle
    end

    // ==============================
    // Arm / capture control
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            armed        <= 1'b0;
            triggered    <= 1'b0;
            capture_done <= 1'b0;
            wr_addr      <= '0;
        end else begin
            capture_done <= 1'b0;
            if (arm_start) begin
                armed     <= 1'b1;
                triggered <= 1'b0;
                wr_addr   <= '0;
            end else if (wr_en) begin
                triggered <= 1'b1;
                wr_addr   <= wr_addr + 1'b1;
                if (wr_addr == hamr_cfg_pkg::CAPTURE_LEN - 1) begin
                    armed        <= 1'b0;   // Last sample written
                    triggered    <= 1'b0;
                    capture_done <= 1'b1;
                end
            end
        end
    end

    // Sample memory
    always_ff @(posedge clk) begin
        if (wr_en)
            sample_mem[wr_addr] <= sample;
        mem_rd_data <= sample_mem[mem_rd_addr];
    end

endmodule

// File: hdl/regen_reader.sv
// Reads DISPLAY_BITS << window samples from address 0, one per clock
// Window is latched at start, so a register write mid-pass has no effect

module regen_reader (
    input  logic                                clk,
    input  logic                                cmd_reset,
    input  logic                                regen_start,
    input  logic [1:0]                          window,
    output logic [hamr_cfg_pkg::CAP_ADDR_W-1:0] mem_rd_addr,
    input  logic [hamr_cfg_pkg::NUM_CH-1:0]     mem_rd_data,
    output logic                                smp_valid,
    output logic [hamr_cfg_pkg::NUM_CH-1:0]     smp_data,
    output logic                                group_end,
    output logic                                regen_done
);

    logic                                active;
    logic [1:0]                          win_q;
    logic [hamr_cfg_pkg::CAP_ADDR_W-1:0] last_addr;
    logic [hamr_cfg_pkg::CAP_ADDR_W-1:0] grp_mask;   // Group size minus one
    logic [2:0]                          done_pipe;

    assign last_addr = ~({hamr_cfg_pkg::CAP_ADDR_W{1'b1}}
                         << ($clog2(hamr_cfg_pkg::DISPLAY_BITS) + win_q));
    assign grp_mask  = ~({hamr_cfg_pkg::CAP_ADDR_W{1'b1}} << win_q);

    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            active      <= 1'b0;
            win_q       <= '0;
            mem_rd_addr <= '0;
            smp_valid   <= 1'b0;
            group_end   <= 1'b0;
            done_pipe   <= '0;
        end else begin
            // Marks line up with the memory's one-cycle latency
            smp_valid <= active;
            group_end <= active && ((mem_rd_addr & grp_mask) == grp_mask);
            done_pipe <= {done_pipe[1:0], active && (mem_rd_addr == last_addr)};
            if (regen_start) begin
                active      <= 1'b1;
                mem_rd_addr <= '0;
                win_q       <= window;      // Every 2-bit code is a legal zoom
            end else if (active) begin
                if (mem_rd_addr == last_addr)
                    active <= 1'b0;         // Last address issued
                else
                    mem_rd_addr <= mem_rd_addr + 1'b1;
            end
        end
    end

    assign smp_data   = mem_rd_data;
    assign regen_done = done_pipe[2];       // Lets the last byte reach the buffer

endmodule

// File: hdl/channel_decimator.sv
// One channel: OR of each group gives one display bit, 8 bits per byte
// Earliest group ends up in bit 7

module channel_decimator (
    input  logic       clk,
    input  logic       cmd_reset,
    input  logic       smp_valid,
    input  logic       smp_bit,
    input  logic       group_end,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    logic       grp_acc;    // OR of the group so far
    logic       grp_or;
    logic [6:0] shreg;      // Earlier groups of this byte
    logic [2:0] grp_cnt;

    assign grp_or = grp_acc | smp_bit;      // Glitches survive decimation

    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            grp_acc    <= 1'b0;
            grp_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (smp_valid && group_end) begin
                grp_acc <= 1'b0;
                grp_cnt <= grp_cnt + 1'b1;
                if (grp_cnt == 3'd7)
                    byte_valid <= 1'b1;     // Eighth group closes the byte
            end else if (smp_valid) begin
                grp_acc <= grp_or;
            end
        end
    end

    // Payload shift path
    always_ff @(posedge clk) begin
        if (smp_valid && group_end) begin
            shreg     <= {shreg[5:0], grp_or};
            byte_data <= {shreg, grp_or};
        end
    end

endmodule

// File: hdl/display_buffer.sv
// Display bytes for all channels, indexed [byte][channel]
// Write index only returns to 0 after DISPLAY_BYTES sets, i.e. a full pass

module display_buffer (
    input  logic                                 clk,
    input  logic                                 cmd_reset,
    input  logic                                 byte_valid,
    input  logic [hamr_cfg_pkg::NUM_CH-1:0][7:0] bytes_in,
    input  logic [2:0]                           sel_ch,
    input  logic [1:0]                           sel_byte,
    output logic [7:0]                           disp_byte
);

    logic [7:0] disp_mem [hamr_cfg_pkg::DISPLAY_BYTES][hamr_cfg_pkg::NUM_CH];
    logic [$clog2(hamr_cfg_pkg::DISPLAY_BYTES)-1:0] wr_idx;

    always_ff @(posedge clk) begin
        if (cmd_reset)
            wr_idx <= '0;
        else if (byte_valid)
            wr_idx <= (wr_idx == hamr_cfg_pkg::DISPLAY_BYTES - 1) ? '0 : wr_idx + 1'b1;
    end

    // All channels land together, decimators run in lockstep
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            for (int ch = 0; ch < hamr_cfg_pkg::NUM_CH; ch++)
                disp_mem[wr_idx][ch] <= bytes_in[ch];
        end
    end

    assign disp_byte = disp_mem[sel_byte][sel_ch];  // Registered in control

endmodule

// File: hdl/analyzer_control.sv
// Register port is a one-cycle strobe bus with no back-pressure
// Commands in a phase that cannot take them are dropped silently
// Arm wins when arm and regen are written together

module analyzer_control (
    input  logic                      clk,
    input  logic                      cmd_reset,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  hamr_types_pkg::reg_addr_t reg_addr,
    input  logic [7:0]                reg_wdata,
    output logic [7:0]                reg_rdata,
    input  logic                      armed,
    input  logic                      capture_done,
    input  logic                      regen_done,
    input  logic [7:0]                disp_byte,
    output logic                      arm_start,
    output logic                      regen_start,
    output logic [2:0]                trig_ch,
    output hamr_types_pkg::trig_mode_t trig_mode,
    output logic [1:0]                window,
    output logic [2:0]                sel_ch,
    output logic [1:0]                sel_byte
);

    hamr_types_pkg::phase_t phase;
    logic ctrl_wr;
    logic arm_ok;
    logic regen_ok;
    logic st_captured;
    logic st_busy;
    logic st_ready;

    // ==============================
    // Command acceptance
    // ==============================
    assign ctrl_wr  = reg_wr && (reg_addr == hamr_types_pkg::REG_CTRL);
    assign arm_ok   = ctrl_wr && reg_wdata[0] && (phase == hamr_types_pkg::PHASE_IDLE
                    || phase == hamr_types_pkg::PHASE_CAPTURED
                    || phase == hamr_types_pkg::PHASE_READY);
    assign regen_ok = ctrl_wr && reg_wdata[1] && !arm_ok
                    && (phase == hamr_types_pkg::PHASE_CAPTURED
                    || phase == hamr_types_pkg::PHASE_READY);   // Re-zoom from ready

    assign st_captured = (phase == hamr_types_pkg::PHASE_CAPTURED)
                      || (phase == hamr_types_pkg::PHASE_REGEN)
                      || (phase == hamr_types_pkg::PHASE_READY);
    assign st_busy  = (phase == hamr_types_pkg::PHASE_CAPTURE)
                   || (phase == hamr_types_pkg::PHASE_REGEN);
    assign st_ready = (phase == hamr_types_pkg::PHASE_READY);

    // ==============================
    // Phase FSM and setup registers
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            phase       <= hamr_types_pkg::PHASE_IDLE;
            arm_start   <= 1'b0;
            regen_start <= 1'b0;
            trig_ch     <= '0;
            trig_mode   <= hamr_types_pkg::TRIG_RISING;
            window      <= '0;
            sel_ch      <= '0;
            sel_byte    <= '0;
            reg_rdata   <= '0;
        end else begin
            arm_start   <= arm_ok;          // One-cycle pulses
            regen_start <= regen_ok;
            case (phase)
                hamr_types_pkg::PHASE_CAPTURE:
                    if (capture_done) phase <= hamr_types_pkg::PHASE_CAPTURED;
                hamr_types_pkg::PHASE_REGEN:
                    if (regen_done) phase <= hamr_types_pkg::PHASE_READY;
                default: begin
                    if (arm_ok)
                        phase <= hamr_types_pkg::PHASE_CAPTURE;
                    else if (regen_ok)
                        phase <= hamr_types_pkg::PHASE_REGEN;
                end
            endcase
            if (reg_wr && reg_addr == hamr_types_pkg::REG_TRIG) begin
                trig_ch   <= reg_wdata[2:0];
                trig_mode <= hamr_types_pkg::trig_mode_t'(reg_wdata[3]);
            end
            if (reg_wr && reg_addr == hamr_types_pkg::REG_WINDOW)
                window <= reg_wdata[1:0];
            if (reg_wr && reg_addr == hamr_types_pkg::REG_SEL) begin
                sel_ch   <= reg_wdata[4:2];
                sel_byte <= reg_wdata[1:0];
            end
            if (reg_rd) begin
                case (reg_addr)
                    hamr_types_pkg::REG_STATUS:
                        reg_rdata <= {4'b0, st_ready, st_busy, st_captured, armed};
                    hamr_types_pkg::REG_DATA: reg_rdata <= disp_byte;
                    default:                  reg_rdata <= '0;
                endcase
            end
        end
    end

endmodule

// File: hdl/logic_analyzer_top.sv
// Eight-channel analyzer core with on-chip sample memory
// Probes may be asynchronous; all else runs on clk

module logic_analyzer_top (
    input  logic                            clk,
    input  logic                            cmd_reset,
    input  logic [hamr_cfg_pkg::NUM_CH-1:0] probe,
    input  logic                            reg_wr,
    input  logic                            reg_rd,
    input  hamr_types_pkg::reg_addr_t       reg_addr,
    input  logic [7:0]                      reg_wdata,
    output logic [7:0]                      reg_rdata
);

    logic                                 sample_strobe;
    logic [hamr_cfg_pkg::NUM_CH-1:0]      sample;
    logic                                 arm_start;
    logic                                 regen_start;
    logic [2:0]                           trig_ch;
    hamr_types_pkg::trig_mode_t           trig_mode;
    logic [1:0]                           window;
    logic [2:0]                           sel_ch;
    logic [1:0]                           sel_byte;
    logic                                 armed;
    logic                                 capture_done;
    logic [hamr_cfg_pkg::CAP_ADDR_W-1:0]  mem_rd_addr;
    logic [hamr_cfg_pkg::NUM_CH-1:0]      mem_rd_data;
    logic                                 smp_valid;
    logic [hamr_cfg_pkg::NUM_CH-1:0]      smp_data;
    logic                                 group_end;
    logic                                 regen_done;
    logic [hamr_cfg_pkg::NUM_CH-1:0]      dec_valid;    // Bit 0 drives the buffer
    logic [hamr_cfg_pkg::NUM_CH-1:0][7:0] dec_bytes;
    logic [7:0]                           disp_byte;

    probe_sampler u_sampler (
        .clk(clk), .cmd_reset(cmd_reset), .probe(probe),
        .sample_strobe(sample_strobe), .sample(sample)
    );

    capture_engine u_capture (
        .clk(clk), .cmd_reset(cmd_reset), .arm_start(arm_start),
        .sample_strobe(sample_strobe), .sample(sample),
        .trig_ch(trig_ch), .trig_mode(trig_mode),
        .armed(armed), .capture_done(capture_done),
        .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
    );

    regen_reader u_reader (
        .clk(clk), .cmd_reset(cmd_reset), .regen_start(regen_start), .window(window),
        .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
        .smp_valid(smp_valid), .smp_data(smp_data),
        .group_end(group_end), .regen_done(regen_done)
    );

    // ==============================
    // Parallel decimation, one per channel
    // ==============================
    for (genvar ch = 0; ch < hamr_cfg_pkg::NUM_CH; ch++) begin : g_dec
        channel_decimator u_dec (
            .clk(clk), .cmd_reset(cmd_reset),
            .smp_valid(smp_valid), .smp_bit(smp_data[ch]), .group_end(group_end),
            .byte_valid(dec_valid[ch]), .byte_data(dec_bytes[ch])
        );
    end

    display_buffer u_display (
        .clk(clk), .cmd_reset(cmd_reset),
        .byte_valid(dec_valid[0]), .bytes_in(dec_bytes),
        .sel_ch(sel_ch), .sel_byte(sel_byte), .disp_byte(disp_byte)
    );

    analyzer_control u_control (
        .clk(clk), .cmd_reset(cmd_reset),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .armed(armed), .capture_done(capture_done), .regen_done(regen_done),
        .disp_byte(disp_byte), .arm_start(arm_start), .regen_start(regen_start),
        .trig_ch(trig_ch), .trig_mode(trig_mode), .window(window),
        .sel_ch(sel_ch), .sel_byte(sel_byte)
    );

endmodule

// File: testbench/analyzer_checker.sv
// Concurrent checks on the phase FSM and its status decode
// Bound into analyzer_control, where the status bits are formed

module analyzer_checker (
    input logic clk,
    input logic cmd_reset,
    input logic armed,
    input logic capture_done,
    input logic busy,
    input logic ready,
    input logic captured
);

    // Busy and ready come from different phases
    busy_ready_excl: assert property (@(posedge clk) disable iff (cmd_reset)
        !(busy && ready))
        else $error("busy and ready high in the same cycle");

    armed_in_busy: assert property (@(posedge clk) disable iff (cmd_reset)
        armed |-> busy)                         // Phase leads armed by a cycle
        else $error("armed set outside a busy phase");

    // Phase moves to captured on the edge after the done pulse
    done_to_captured: assert property (@(posedge clk) disable iff (cmd_reset)
        capture_done |=> captured)
        else $error("capture_done not followed by captured status");

endmodule

bind analyzer_control analyzer_checker checker_inst (
    .clk(clk), .cmd_reset(cmd_reset), .armed(armed), .capture_done(capture_done),
    .busy(st_busy), .ready(st_ready), .captured(st_captured)
);

// File: testbench/tb_logic_analyzer.sv
// Random probes change only on sample-period boundaries, so the model sees
// exactly the sample stream that the capture engine sees
// Runs two captures with four regenerations in all

module tb_logic_analyzer;

    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned TIMEOUT_CYCLES =
        4 * hamr_cfg_pkg::CAPTURE_LEN * hamr_cfg_pkg::SAMPLE_DIV  // Captures
        + 4 * (hamr_cfg_pkg::CAPTURE_LEN + 256)                   // Regens and readback
        + 4000;                                                   // Margin
    localparam logic [7:0] ST_ARMING   = 8'h05;   // armed, busy
    localparam logic [7:0] ST_HANDOFF  = 8'h04;   // Armed drops a cycle before the phase
    localparam logic [7:0] ST_CAPTURED = 8'h02;
    localparam logic [7:0] ST_REGEN    = 8'h06;   // captured, busy
    localparam logic [7:0] ST_READY    = 8'h0A;   // captured, ready

    logic                            clk;
    logic                            cmd_reset;
    logic [hamr_cfg_pkg::NUM_CH-1:0] probe;
    logic                            reg_wr;
    logic                            reg_rd;
    hamr_types_pkg::reg_addr_t       reg_addr;
    logic [7:0]                      reg_wdata;
    logic [7:0]                      reg_rdata;

    logic [7:0] samples [$];                          // One entry per sample period
    logic [7:0] cap [hamr_cfg_pkg::CAPTURE_LEN];      // Model's copy of the capture
    logic       hold_en;
    logic [2:0] hold_ch;
    logic       hold_lvl;                             // Pre-edge level of the trigger bit
    int         rel_idx;                              // First random sample after a hold
    int         checks;
    int         errors;
    int         cycles;

    logic_analyzer_top logic_analyzer_top_inst (
        .clk(clk), .cmd_reset(cmd_reset), .probe(probe),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Probe stream
    // ==============================
    initial begin : probe_driver
        logic [7:0] pv;
        logic       was_held;
        void'($urandom(11954));
        probe    = '0;
        rel_idx  = 1;
        was_held = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);   // Same edge that releases reset
        forever begin
            pv = 8'($urandom);
            if (hold_en)
                pv[hold_ch] = hold_lvl;
            else if (was_held)
                rel_idx = samples.size();       // Trigger search starts here
            was_held = hold_en;
            probe <= pv;
            samples.push_back(pv);
            repeat (hamr_cfg_pkg::SAMPLE_DIV) @(posedge clk);
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT never reached the expected status", cycles);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got=%02h exp=%02h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input hamr_types_pkg::reg_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input hamr_types_pkg::reg_addr_t addr, output logic [7:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd   <= 1'b0;
        @(negedge clk);                         // rdata settled mid-cycle
        data = reg_rdata;
    endtask

    // Poll status until bit_idx sets, checking the busy code on the way
    task automatic wait_status(input int bit_idx, input logic [7:0] busy_code,
                               input logic [7:0] alt_code, output logic [7:0] st);
        read_reg(hamr_types_pkg::REG_STATUS, st);
        while (!st[bit_idx]) begin
            if (st !== alt_code)
                check_value("status", st, busy_code);
            read_reg(hamr_types_pkg::REG_STATUS, st);
        end
    endtask

    function automatic logic is_trig_edge(input int k, input logic [2:0] ch, input logic lvl);
        logic [7:0] prev_s;
        logic [7:0] cur_s;
        prev_s = samples[k-1];
        cur_s  = samples[k];
        return (prev_s[ch] == lvl) && (cur_s[ch] != lvl);
    endfunction

    // OR over each group, earliest group in bit 7
    function automatic logic [7:0] model_byte(input int ch, input int b, input logic [1:0] win);
        logic [7:0] result;
        logic [7:0] s;
        int         width;
        result = '0;
        width  = 1 << win;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < width; j++) begin
                s = cap[(b * 8 + i) * width + j];
                if (s[ch])
                    result[7 - i] = 1'b1;
            end
        end
        return result;
    endfunction

    // ==============================
    // Capture and regeneration
    // ==============================
    task automatic run_capture(input logic [2:0] ch, input hamr_types_pkg::trig_mode_t mode);
        logic [7:0] st;
        int         k;
        hold_ch  = ch;
        hold_lvl = (mode == hamr_types_pkg::TRIG_FALLING);
        hold_en  = 1'b1;
        repeat (3 * hamr_cfg_pkg::SAMPLE_DIV) @(posedge clk);  // Held samples reach engine
        write_reg(hamr_types_pkg::REG_TRIG, {4'b0, mode, ch});
        write_reg(hamr_types_pkg::REG_CTRL, 8'h01);
        read_reg(hamr_types_pkg::REG_STATUS, st);
        check_value("status armed", st, ST_ARMING);
        hold_en = 1'b0;                                        // Edge can come now
        wait_status(1, ST_ARMING, ST_HANDOFF, st);
        check_value("status captured", st, ST_CAPTURED);
        k = rel_idx;
        while (k + hamr_cfg_pkg::CAPTURE_LEN <= samples.size() && !is_trig_edge(k, ch, hold_lvl))
            k++;
        assert (k + hamr_cfg_pkg::CAPTURE_LEN <= samples.size()) else begin
            errors++;
            $display("No trigger edge on channel %0d in the recorded probe stream", ch);
        end
        for (int i = 0; i < hamr_cfg_pkg::CAPTURE_LEN; i++)
            cap[i] = samples[k + i];
    endtask

    task automatic run_regen(input logic [1:0] win);
        logic [7:0] st;
        logic [7:0] got;
        write_reg(hamr_types_pkg::REG_WINDOW, {6'b0, win});
        write_reg(hamr_types_pkg::REG_CTRL, 8'h02);
        wait_status(3, ST_REGEN, ST_REGEN, st);
        check_value("status ready", st, ST_READY);
        for (int ch = 0; ch < hamr_cfg_pkg::NUM_CH; ch++) begin
            for (int b = 0; b < hamr_cfg_pkg::DISPLAY_BYTES; b++) begin
                write_reg(hamr_types_pkg::REG_SEL, 8'((ch << 2) | b));
                read_reg(hamr_types_pkg::REG_DATA, got);
                check_value($sformatf("disp_byte ch%0d byte%0d win%0d", ch, b, win),
                            got, model_byte(ch, b, win));
            end
        end
    endtask

    initial begin : main_sequence
        logic [7:0] st;
        cmd_reset = 1'b1;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = hamr_types_pkg::REG_CTRL;
        reg_wdata = '0;
        hold_en   = 1'b0;
        hold_ch   = '0;
        hold_lvl  = 1'b0;
        checks    = 0;
        errors    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        cmd_reset <= 1'b0;

        read_reg(hamr_types_pkg::REG_STATUS, st);
        check_value("status after reset", st, 8'h00);
        write_reg(hamr_types_pkg::REG_CTRL, 8'h02);            // Regen in idle, ignored
        read_reg(hamr_types_pkg::REG_STATUS, st);
        check_value("status after idle regen", st, 8'h00);

        run_capture(3'd5, hamr_types_pkg::TRIG_RISING);
        run_regen(2'd0);
        run_regen(2'd2);                                       // Re-zoom, same capture
        run_regen(2'd3);                                       // Groups of 8 samples
        run_capture(3'd2, hamr_types_pkg::TRIG_FALLING);
        run_regen(2'd1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/hamr_cfg_pkg.sv
hdl/hamr_types_pkg.sv
hdl/probe_sampler.sv
hdl/capture_engine.sv
hdl/regen_reader.sv
hdl/channel_decimator.sv
hdl/display_buffer.sv
hdl/analyzer_control.sv
hdl/logic_analyzer_top.sv
testbench/analyzer_checker.sv
testbench/tb_logic_analyzer.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_logic_analyzer
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
